// File: flist.f
hdl/board_pkg.sv
hdl/reset_sync.sv
hdl/rtc_divider.sv
hdl/fan_ctrl.sv
hdl/ctrl_regs.sv
hdl/board_top.sv
verification/tb_board_top.sv

// File: Makefile
# Verilator build and run for the board glue testbench

VERILATOR ?= verilator
TOP       := tb_board_top
FLIST     := flist.f
OBJ_DIR   := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)

BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FLIST))
FAIL_MSG  := FAIL: see errors above

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "PASS: all tests" $(LOG) || { echo "Simulation did not finish"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/tb_board_top.sv
/*
 * Testbench for the board glue top level
 *   - reset, random Wishbone traffic, boot-mode override
 *   - RTC period, fan PWM duty, soft reset sequence
 *   - reference model of the control register and decode
 */
`timescale 1ns/1ps

module tb_board_top import board_pkg::*; ();

  localparam int ClkPeriodNs   = 20;
  localparam int ResetLen      = 4;
  localparam int SocFreqHz     = 50_000_000;
  localparam int RtcFreqHz     = 1_000_000;
  localparam int FanSlotCycles = 4;
  localparam int RtcHalfPeriod = SocFreqHz / (2 * RtcFreqHz);
  localparam int RtcPeriod     = 2 * RtcHalfPeriod;
  localparam int FrameCycles   = 16 * FanSlotCycles;
  localparam int TrafficRuns   = 200;
  localparam int BootRuns      = 40;
  localparam int FanRuns       = 8;
  localparam int SoftHold      = 60;
  localparam int ReplyTimeout  = 8;

  // Rough cycle budget per test, for the watchdog
  localparam int TotalCycles = (ResetLen + 10) + (TrafficRuns * 2 + 20) + (BootRuns * 5 + 10)
                             + (20 + RtcHalfPeriod + 4 * RtcPeriod)
                             + (FanRuns * 4 * FrameCycles) + (SoftHold + 20);
  localparam int WatchdogNs = TotalCycles * ClkPeriodNs + (TotalCycles * ClkPeriodNs) / 2;

  logic        soc_clk;
  logic        rst_n;
  logic        test_mode_i;
  boot_mode_t  boot_mode_i;
  fan_level_t  fan_sw_i;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  boot_mode_t  boot_mode_o;
  logic        soc_rst_n_o;
  logic        rtc_o;
  logic        fan_pwm_o;

  // Model of the control register: ovr_sel, ovr_mode[1:0], soft_rst
  logic [3:0]  ctrl_m;
  soc_data_t   rd;
  int          errors;
  int          test_err_start;
  int          tests_run;
  int          tests_failed;

  board_top #(
    .SocFreqHz     ( SocFreqHz     ),
    .RtcFreqHz     ( RtcFreqHz     ),
    .FanSlotCycles ( FanSlotCycles )
  ) u_board_top (
    .soc_clk     ( soc_clk     ),
    .rst_n       ( rst_n       ),
    .test_mode_i ( test_mode_i ),
    .boot_mode_i ( boot_mode_i ),
    .fan_sw_i    ( fan_sw_i    ),
    .wb_req_i    ( wb_req      ),
    .wb_rsp_o    ( wb_rsp      ),
    .boot_mode_o ( boot_mode_o ),
    .soc_rst_n_o ( soc_rst_n_o ),
    .rtc_o       ( rtc_o       ),
    .fan_pwm_o   ( fan_pwm_o   )
  );

  initial begin
    soc_clk = 1'b0;
    forever #(ClkPeriodNs / 2) soc_clk = ~soc_clk;
  end

  initial begin
    #(WatchdogNs);
    $display("Watchdog expired after %0d ns, the tests did not complete", WatchdogNs);
    $display("FAIL: see errors above");
    $finish;
  end

  //////////////////////////////
  // Reporting
  //////////////////////////////

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("ERROR %s: expected 0x%0h, got 0x%0h at %0t", name, exp, got, $time);
    errors++;
  endtask

  task automatic report_problem(input string msg);
    $display("Problem at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic close_test(input string name);
    tests_run++;
    if (errors == test_err_start) begin
      $display("%s: done, no errors", name);
    end else begin
      tests_failed++;
      $display("%s: done, %0d errors", name, errors - test_err_start);
    end
    test_err_start = errors;
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic boot_mode_t effective_boot();
    return ctrl_m[3] ? ctrl_m[2:1] : boot_mode_i;
  endfunction

  function automatic logic is_valid_request(input soc_addr_t adr);
    logic in_region;
    soc_addr_t off;
    in_region = (adr >= ExtRegionStart) && (adr < ExtRegionEnd);
    off = adr - ExtRegionStart;
    return in_region && (adr[1:0] == 2'b00) && (off == CtrlOffset || off == StatusOffset);
  endfunction

  function automatic soc_data_t model_read(input soc_addr_t adr);
    soc_data_t d;
    d = '0;
    if (adr == ExtRegionStart + CtrlOffset) begin
      d[3:0] = ctrl_m;
    end else if (adr == ExtRegionStart + StatusOffset) begin
      // test_mode_i is held low for the whole run
      d[3:0] = {ctrl_m[0], 1'b0, effective_boot()};
    end
    return d;
  endfunction

  function automatic soc_addr_t random_address();
    soc_addr_t a;
    case ($urandom_range(0, 9))
      0, 1:    a = ExtRegionStart + CtrlOffset;
      2, 3:    a = ExtRegionStart + StatusOffset;
      4:       a = ExtRegionStart + soc_addr_t'($urandom_range(1, 7));
      5:       a = ExtRegionStart + ($urandom & 32'h000F_FFFC);
      6:       a = ExtRegionEnd - soc_addr_t'($urandom_range(0, 4));
      7:       a = ExtRegionStart - 32'h4;
      default: a = $urandom;
    endcase
    return a;
  endfunction

  //////////////////////////////
  // Bus access
  //////////////////////////////

  // Starts and ends on a falling edge, with one idle cycle after the reply
  task automatic bus_transfer(input soc_addr_t adr, input logic we, input soc_data_t dat,
                              input byte_sel_t sel, output logic ack, output logic err,
                              output soc_data_t rdat);
    int waited;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = dat;
    wb_req.sel = sel;
    waited = 0;
    do begin
      @(negedge soc_clk);
      waited++;
    end while (!(wb_rsp.ack || wb_rsp.err) && waited < ReplyTimeout);
    ack  = wb_rsp.ack;
    err  = wb_rsp.err;
    rdat = wb_rsp.dat;
    wb_req = '0;
    @(negedge soc_clk);
    if (!ack && !err) begin
      report_problem($sformatf("no bus reply for address 0x%08h", adr));
    end else if (waited != 1) begin
      report_problem($sformatf("bus reply took %0d cycles instead of 1", waited));
    end
  endtask

  task automatic reg_access(input soc_addr_t adr, input logic we, input soc_data_t dat,
                            input byte_sel_t sel, output soc_data_t rdat);
    logic ack;
    logic err;
    logic valid;
    soc_data_t exp_rd;
    valid  = is_valid_request(adr);
    exp_rd = model_read(adr);
    bus_transfer(adr, we, dat, sel, ack, err, rdat);
    if (ack != valid) report_mismatch("wb_rsp_o.ack", 32'(valid), 32'(ack));
    if (err != !valid) report_mismatch("wb_rsp_o.err", 32'(!valid), 32'(err));
    if (err && rdat != '0) report_mismatch("wb_rsp_o.dat", 32'h0, rdat);
    if (ack && !we && rdat != exp_rd) report_mismatch("wb_rsp_o.dat", exp_rd, rdat);
    if (ack && we && adr == ExtRegionStart + CtrlOffset && sel[0]) begin
      ctrl_m = dat[3:0];
    end
  endtask

  task automatic await_soc_release();
    int waited;
    waited = 0;
    while (!soc_rst_n_o && waited < 8) begin
      @(negedge soc_clk);
      waited++;
    end
    if (!soc_rst_n_o) report_problem("soc_rst_n_o did not release after soft reset cleared");
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic after_reset_checks();
    repeat (ResetLen) @(negedge soc_clk);
    rst_n = 1'b1;
    @(negedge soc_clk);
    if (soc_rst_n_o) report_mismatch("soc_rst_n_o", 32'h0, 32'h1);
    @(negedge soc_clk);
    if (!soc_rst_n_o) report_mismatch("soc_rst_n_o", 32'h1, 32'h0);
    if (wb_rsp.ack) report_mismatch("wb_rsp_o.ack", 32'h0, 32'h1);
    if (wb_rsp.err) report_mismatch("wb_rsp_o.err", 32'h0, 32'h1);
    if (rtc_o) report_mismatch("rtc_o", 32'h0, 32'h1);
    if (fan_pwm_o) report_mismatch("fan_pwm_o", 32'h0, 32'h1);
    if (boot_mode_o != boot_mode_i) report_mismatch("boot_mode_o", 32'(boot_mode_i),
                                                    32'(boot_mode_o));
  endtask

  task automatic register_traffic();
    soc_addr_t adr;
    logic      we;
    byte_sel_t sel;
    repeat (TrafficRuns) begin
      boot_mode_i = boot_mode_t'($urandom_range(0, 3));
      adr = random_address();
      we  = $urandom_range(0, 1) != 0;
      sel = byte_sel_t'($urandom_range(0, 15));
      reg_access(adr, we, $urandom, sel, rd);
    end
    reg_access(ExtRegionStart, 1'b1, 32'h0, 4'h1, rd);
    await_soc_release();
  endtask

  task automatic boot_mode_override();
    logic       sel_ovr;
    boot_mode_t mode;
    repeat (BootRuns) begin
      boot_mode_i = boot_mode_t'($urandom_range(0, 3));
      sel_ovr = $urandom_range(0, 1) != 0;
      mode = boot_mode_t'($urandom_range(0, 3));
      reg_access(ExtRegionStart, 1'b1, {28'h0, sel_ovr, mode, 1'b0}, 4'h1, rd);
      if (boot_mode_o != effective_boot()) report_mismatch("boot_mode_o",
          32'(effective_boot()), 32'(boot_mode_o));
      reg_access(ExtRegionStart + StatusOffset, 1'b0, 32'h0, 4'hf, rd);
      // Pin change alone, no register write
      boot_mode_i = boot_mode_t'($urandom_range(0, 3));
      @(negedge soc_clk);
      if (boot_mode_o != effective_boot()) report_mismatch("boot_mode_o",
          32'(effective_boot()), 32'(boot_mode_o));
    end
  endtask

  task automatic rtc_timing();
    int   cnt;
    logic prev;
    logic rising;
    reg_access(ExtRegionStart, 1'b1, 32'h1, 4'h1, rd);
    reg_access(ExtRegionStart, 1'b1, 32'h0, 4'h1, rd);
    await_soc_release();
    cnt = 0;
    while (!rtc_o && cnt < 4 * RtcHalfPeriod) begin
      @(negedge soc_clk);
      cnt++;
    end
    if (cnt != RtcHalfPeriod) report_mismatch("rtc_o first rise", 32'(RtcHalfPeriod), 32'(cnt));
    for (int p = 0; p < 3; p++) begin
      cnt = 0;
      prev = rtc_o;
      rising = 1'b0;
      while (!rising && cnt < 2 * RtcPeriod) begin
        @(negedge soc_clk);
        cnt++;
        rising = rtc_o && !prev;
        prev = rtc_o;
      end
      if (cnt != RtcPeriod) report_mismatch("rtc_o period", 32'(RtcPeriod), 32'(cnt));
    end
  endtask

  task automatic fan_duty();
    fan_level_t lvl;
    int         high;
    int         exp_high;
    for (int r = 0; r < FanRuns; r++) begin
      lvl = fan_level_t'($urandom_range(0, 15));
      fan_sw_i = lvl;
      // Two frames cover the synchronizer and the next frame start
      repeat (2 * FrameCycles + $urandom_range(0, FrameCycles - 1)) @(negedge soc_clk);
      high = 0;
      repeat (FrameCycles) begin
        @(negedge soc_clk);
        if (fan_pwm_o) high++;
      end
      exp_high = int'(lvl) * FanSlotCycles;
      if (high != exp_high) report_mismatch("fan_pwm_o high cycles", 32'(exp_high), 32'(high));
    end
  endtask

  task automatic soft_reset_sequence();
    logic held;
    fan_sw_i = 4'hf;
    reg_access(ExtRegionStart, 1'b1, 32'h1, 4'h1, rd);
    if (soc_rst_n_o) report_mismatch("soc_rst_n_o", 32'h0, 32'h1);
    held = 1'b1;
    repeat (SoftHold) begin
      @(negedge soc_clk);
      if (soc_rst_n_o || rtc_o || fan_pwm_o) held = 1'b0;
    end
    if (!held) report_problem("soc_rst_n_o, rtc_o or fan_pwm_o went high during soft reset");
    reg_access(ExtRegionStart, 1'b0, 32'h0, 4'hf, rd);
    reg_access(ExtRegionStart + StatusOffset, 1'b0, 32'h0, 4'hf, rd);
    reg_access(ExtRegionStart, 1'b1, 32'h0, 4'h1, rd);
    if (soc_rst_n_o) report_mismatch("soc_rst_n_o", 32'h0, 32'h1);
    @(negedge soc_clk);
    if (!soc_rst_n_o) report_mismatch("soc_rst_n_o", 32'h1, 32'h0);
  endtask

  initial begin
    void'($urandom(32'h80c7));
    errors = 0;
    test_err_start = 0;
    tests_run = 0;
    tests_failed = 0;
    ctrl_m = '0;
    rst_n = 1'b0;
    test_mode_i = 1'b0;
    boot_mode_i = boot_mode_t'($urandom_range(0, 3));
    fan_sw_i = '0;
    wb_req = '0;
    after_reset_checks();
    close_test("after_reset");
    register_traffic();
    close_test("register_traffic");
    boot_mode_override();
    close_test("boot_mode");
    rtc_timing();
    close_test("rtc");
    fan_duty();
    close_test("fan");
    soft_reset_sequence();
    close_test("soft_reset");
    $display("Summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: hdl/board_top.sv
/*
 * Board glue top level
 *   - reset synchronizer with soft reset
 *   - RTC divider and fan PWM on the SoC reset
 *   - control registers on the Wishbone register port
 */
`timescale 1ns/1ps

module board_top import board_pkg::*; #(
  parameter int unsigned SocFreqHz     = 50_000_000,
  parameter int unsigned RtcFreqHz     = 1_000_000,
  parameter int unsigned FanSlotCycles = 4
) (
  input  logic       soc_clk,
  input  logic       rst_n,
  input  logic       test_mode_i,
  input  boot_mode_t boot_mode_i,
  input  fan_level_t fan_sw_i,
  input  wb_req_t    wb_req_i,
  output wb_rsp_t    wb_rsp_o,
  output boot_mode_t boot_mode_o,
  output logic       soc_rst_n_o,
  output logic       rtc_o,
  output logic       fan_pwm_o
);

  logic soft_rst;
  logic cfg_rst_n;
  logic soc_rst_n;

  //////////////////////////////
  // Reset
  //////////////////////////////

  reset_sync u_reset_sync (
    .soc_clk     ( soc_clk     ),
    .rst_n       ( rst_n       ),
    .test_mode_i ( test_mode_i ),
    .soft_rst_i  ( soft_rst    ),
    .cfg_rst_n_o ( cfg_rst_n   ),
    .soc_rst_n_o ( soc_rst_n   )
  );

  assign soc_rst_n_o = soc_rst_n;

  //////////////////////////////
  // RTC and fan
  //////////////////////////////

  rtc_divider #(
    .SocFreqHz ( SocFreqHz ),
    .RtcFreqHz ( RtcFreqHz )
  ) u_rtc_divider (
    .soc_clk ( soc_clk   ),
    .rst_n   ( soc_rst_n ),
    .rtc_o   ( rtc_o     )
  );

  fan_ctrl #(
    .FanSlotCycles ( FanSlotCycles )
  ) u_fan_ctrl (
    .soc_clk   ( soc_clk   ),
    .rst_n     ( soc_rst_n ),
    .fan_sw_i  ( fan_sw_i  ),
    .fan_pwm_o ( fan_pwm_o )
  );

  //////////////////////////////
  // Control registers
  //////////////////////////////

  // Config reset only, so the soft reset bit survives its own effect
  ctrl_regs u_ctrl_regs (
    .soc_clk     ( soc_clk     ),
    .rst_n       ( cfg_rst_n   ),
    .test_mode_i ( test_mode_i ),
    .boot_mode_i ( boot_mode_i ),
    .wb_req_i    ( wb_req_i    ),
    .wb_rsp_o    ( wb_rsp_o    ),
    .soft_rst_o  ( soft_rst    ),
    .boot_mode_o ( boot_mode_o )
  );

endmodule

// File: hdl/ctrl_regs.sv
/*
 * Control and status registers on the external register region
 *   - Wishbone classic slave, one-cycle ack or err reply
 *   - control: soft reset, boot-mode override and override select
 *   - status: effective boot mode, test mode, soft reset active
 */
`timescale 1ns/1ps

module ctrl_regs import board_pkg::*; (
  input  logic       soc_clk,
  input  logic       rst_n,
  input  logic       test_mode_i,
  input  boot_mode_t boot_mode_i,
  input  wb_req_t    wb_req_i,
  output wb_rsp_t    wb_rsp_o,
  output logic       soft_rst_o,
  output boot_mode_t boot_mode_o
);

  soc_addr_t   offset;
  logic        in_region;
  logic        aligned;
  logic        hit_ctrl;
  logic        hit_status;
  logic        req_valid;
  logic        strobe;
  logic        ctrl_write;
  ctrl_reg_t   ctrl_q;
  status_reg_t status;
  soc_data_t   rdata;
  wb_rsp_t     rsp_q;

  //////////////////////////////
  // Address decode
  //////////////////////////////

  assign in_region = (wb_req_i.adr >= ExtRegionStart) && (wb_req_i.adr < ExtRegionEnd);
  assign offset    = wb_req_i.adr - ExtRegionStart;
  assign aligned   = (wb_req_i.adr[1:0] == 2'b00);

  assign hit_ctrl   = in_region && (offset == CtrlOffset);
  assign hit_status = in_region && (offset == StatusOffset);
  assign req_valid  = aligned && (hit_ctrl || hit_status);

  // Strobe is ignored while the reply to the previous request is out
  assign strobe = wb_req_i.cyc && wb_req_i.stb && !rsp_q.ack && !rsp_q.err;

  // Only byte lane 0 holds writable bits
  assign ctrl_write = strobe && req_valid && wb_req_i.we && hit_ctrl && wb_req_i.sel[0];

  //////////////////////////////
  // Registers
  //////////////////////////////

  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      ctrl_q <= '0;
    end else if (ctrl_write) begin
      ctrl_q <= wb_req_i.dat[$bits(ctrl_reg_t)-1:0];
    end
  end

  // Override wins when selected
  assign boot_mode_o = ctrl_q.ovr_sel ? ctrl_q.ovr_mode : boot_mode_i;
  assign soft_rst_o  = ctrl_q.soft_rst;

  assign status = '{
    soft_rst_active: ctrl_q.soft_rst,
    test_mode:       test_mode_i,
    boot_mode:       boot_mode_o
  };

  // Read mux, unused bits are zero
  always_comb begin
    rdata = '0;
    if (hit_ctrl) begin
      rdata[$bits(ctrl_reg_t)-1:0] = ctrl_q;
    end else if (hit_status) begin
      rdata[$bits(status_reg_t)-1:0] = status;
    end
  end

  //////////////////////////////
  // Reply
  //////////////////////////////

  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      rsp_q <= '0;
    end else begin
      rsp_q.ack <= strobe && req_valid;
      rsp_q.err <= strobe && !req_valid;
      // Data only on a read ack, zero for writes and errors
      rsp_q.dat <= (strobe && req_valid && !wb_req_i.we) ? rdata : '0;
    end
  end

  assign wb_rsp_o = rsp_q;

  //////////////////////////////
  // Checks
  //////////////////////////////

  a_ack_err_excl: assert property (
    @(posedge soc_clk) disable iff (!rst_n)
    !(wb_rsp_o.ack && wb_rsp_o.err)
  );

endmodule

// File: hdl/fan_ctrl.sv
/*
 * Fan PWM controller
 *   - two-flop synchronizer on the switch level
 *   - level latched at each frame start
 *   - 16 slots per frame, high while slot index is below the level
 */
`timescale 1ns/1ps

module fan_ctrl import board_pkg::*; #(
  parameter int unsigned FanSlotCycles = 4
) (
  input  logic       soc_clk,
  input  logic       rst_n,
  input  fan_level_t fan_sw_i,
  output logic       fan_pwm_o
);

  localparam int unsigned SlotCntWidth = (FanSlotCycles > 1) ? $clog2(FanSlotCycles) : 1;

  typedef logic [SlotCntWidth-1:0] slot_cnt_t;

  localparam slot_cnt_t  SlotCntMax = slot_cnt_t'(FanSlotCycles - 1);
  localparam fan_level_t LastSlot   = '1;

  fan_level_t sw_meta_q;
  fan_level_t sw_sync_q;
  fan_level_t level_q;
  fan_level_t slot_idx_q;
  slot_cnt_t  slot_cnt_q;
  logic       slot_end;
  logic       frame_end;

  // Switches are asynchronous to soc_clk
  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      sw_meta_q <= '0;
      sw_sync_q <= '0;
    end else begin
      sw_meta_q <= fan_sw_i;
      sw_sync_q <= sw_meta_q;
    end
  end

  assign slot_end  = (slot_cnt_q == SlotCntMax);
  assign frame_end = slot_end && (slot_idx_q == LastSlot);

  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      slot_cnt_q <= '0;
      slot_idx_q <= '0;
      level_q    <= '0;
    end else begin
      slot_cnt_q <= slot_end ? '0 : slot_cnt_q + 1'b1;
      // Slot index wraps from 15 to 0 on its own
      if (slot_end) begin
        slot_idx_q <= slot_idx_q + 1'b1;
      end
      // New level only at frame boundary, so a frame never gets a partial duty
      if (frame_end) begin
        level_q <= sw_sync_q;
      end
    end
  end

  assign fan_pwm_o = (slot_idx_q < level_q);

endmodule

// File: hdl/rtc_divider.sv
/*
 * RTC clock divider
 *   - half period derived from the SoC and RTC frequencies
 *   - wrap counter and toggle flop, output low in reset
 */
`timescale 1ns/1ps

module rtc_divider #(
  parameter int unsigned SocFreqHz = 50_000_000,
  parameter int unsigned RtcFreqHz = 1_000_000
) (
  input  logic soc_clk,
  input  logic rst_n,
  output logic rtc_o
);

  // 50 MHz / 1 MHz gives 25 cycles per half period
  localparam int unsigned RtcHalfPeriod = SocFreqHz / (2 * RtcFreqHz);
  localparam int unsigned CntWidth = (RtcHalfPeriod > 1) ? $clog2(RtcHalfPeriod) : 1;

  typedef logic [CntWidth-1:0] rtc_cnt_t;

  localparam rtc_cnt_t CntMax = rtc_cnt_t'(RtcHalfPeriod - 1);

  rtc_cnt_t cnt_q;
  logic     wrap;
  logic     rtc_q;

  assign wrap = (cnt_q == CntMax);

  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
      rtc_q <= 1'b0;
    end else begin
      cnt_q <= wrap ? '0 : cnt_q + 1'b1;
      // Toggle once per half period
      rtc_q <= rtc_q ^ wrap;
    end
  end

  assign rtc_o = rtc_q;

  //////////////////////////////
  // Checks
  //////////////////////////////

  a_cnt_range: assert property (
    @(posedge soc_clk) disable iff (!rst_n)
    cnt_q <= CntMax
  );

endmodule

// File: hdl/reset_sync.sv
/*
 * Reset synchronizer for the board glue
 *   - config reset from the board reset alone
 *   - SoC reset from the board reset and the soft reset
 *   - async assert, two-flop sync release, test-mode bypass
 */
`timescale 1ns/1ps

module reset_sync (
  input  logic soc_clk,
  input  logic rst_n,
  input  logic test_mode_i,
  input  logic soft_rst_i,
  output logic cfg_rst_n_o,
  output logic soc_rst_n_o
);

  localparam int unsigned CfgDom = 0;
  localparam int unsigned SocDom = 1;

  // Raw async reset per domain, active low
  logic [1:0] arst_n;
  logic [1:0] meta_q;
  logic [1:0] sync_q;

  // Config domain must not see the soft reset, else it would clear itself
  assign arst_n[CfgDom] = rst_n;
  assign arst_n[SocDom] = rst_n && !soft_rst_i;

  for (genvar g = 0; g < 2; g++) begin : gen_sync
    always_ff @(posedge soc_clk, negedge arst_n[g]) begin
      if (!arst_n[g]) begin
        meta_q[g] <= 1'b0;
        sync_q[g] <= 1'b0;
      end else begin
        meta_q[g] <= 1'b1;
        sync_q[g] <= meta_q[g];
      end
    end
  end

  // Scan and test runs drive the raw reset straight through
  assign cfg_rst_n_o = test_mode_i ? arst_n[CfgDom] : sync_q[CfgDom];
  assign soc_rst_n_o = test_mode_i ? arst_n[SocDom] : sync_q[SocDom];

  //////////////////////////////
  // Checks
  //////////////////////////////

  // SoC held in reset with config alive only while a soft reset is
  // pending or still draining through the two sync stages
  a_soc_rst_cause: assert property (
    @(posedge soc_clk) disable iff (!rst_n)
    (cfg_rst_n_o && !soc_rst_n_o) |->
      (soft_rst_i || $past(soft_rst_i) || $past(soft_rst_i, 2))
  );

endmodule

// File: hdl/board_pkg.sv
/*
 * Shared board glue definitions
 *   - width typedefs for bus words, byte selects, boot mode and fan level
 *   - Wishbone classic request and response structs
 *   - external register region bounds and control/status register layout
 */
package board_pkg;

  typedef logic [31:0] soc_addr_t;
  typedef logic [31:0] soc_data_t;
  typedef logic [3:0]  byte_sel_t;
  typedef logic [1:0]  boot_mode_t;
  typedef logic [3:0]  fan_level_t;

  //////////////////////////////
  // Wishbone classic
  //////////////////////////////

  typedef struct packed {
    logic      cyc;
    logic      stb;
    logic      we;
    soc_addr_t adr;
    soc_data_t dat;
    byte_sel_t sel;
  } wb_req_t;

  typedef struct packed {
    logic      ack;
    logic      err;
    soc_data_t dat;
  } wb_rsp_t;

  //////////////////////////////
  // Register map
  //////////////////////////////

  // End bound is exclusive
  localparam soc_addr_t ExtRegionStart = 32'h4000_0000;
  localparam soc_addr_t ExtRegionEnd   = 32'h4010_0000;

  localparam soc_addr_t CtrlOffset   = 32'h0000_0000;
  localparam soc_addr_t StatusOffset = 32'h0000_0004;

  // Control register, bits 3:0 of the word
  typedef struct packed {
    logic       ovr_sel;
    boot_mode_t ovr_mode;
    logic       soft_rst;
  } ctrl_reg_t;

  // Status register, bits 3:0 of the word, read only
  typedef struct packed {
    logic       soft_rst_active;
    logic       test_mode;
    boot_mode_t boot_mode;
  } status_reg_t;

endpackage
